//--- Bender.yml
package:
  name: ahbLite

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ahbLitePkg.sv
      - hdl/ahbSlaveIf.sv
      - hdl/busFabric.sv
      - hdl/dataMemAhb.sv
      - hdl/ioShim.sv
      - hdl/ahbLite.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/ahbLiteChecker.sv
      - tests/ahbLiteTb.sv

//--- compile.f
+incdir+hdl
hdl/ahbLitePkg.sv
hdl/ahbSlaveIf.sv
hdl/busFabric.sv
hdl/dataMemAhb.sv
hdl/ioShim.sv
hdl/ahbLite.sv
tests/ahbLiteChecker.sv
tests/ahbLiteTb.sv

//--- hdl/ahbLite.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahbLite_defines.svh"

// top level: one master port, data memory at region 0, io at region 4
module ahbLite
  import ahbLitePkg::*;
(
  input  logic                  HCLK,
  input  logic                  arstN,
  input  logic                  HREQUEST,
  input  hSizeT                 HSIZE,
  input  logic [31:0]           HADDR,
  input  logic                  HWRITE,
  input  logic [31:0]           HWDATA,
  input  logic [`SIC_WIDTH-1:0] sicSources,
  output logic [31:0]           HRDATA,
  output logic                  HREADY,
  output logic                  irq,
  output logic                  fiq
);

  // one bundle per slave
  ahbSlaveIf memBus ();
  ahbSlaveIf ioBus ();

  // decode and response mux
  busFabric i_busFabric (
    .HCLK     (HCLK),
    .arstN    (arstN),
    .HREQUEST (HREQUEST),
    .HSIZE    (HSIZE),
    .HADDR    (HADDR),
    .HWRITE   (HWRITE),
    .HWDATA   (HWDATA),
    .HRDATA   (HRDATA),
    .HREADY   (HREADY),
    .memBus   (memBus.fabric),
    .ioBus    (ioBus.fabric)
  );

  // data memory, one wait state
  dataMemAhb i_dataMemAhb (
    .HCLK  (HCLK),
    .arstN (arstN),
    .bus   (memBus.slave)
  );

  // sic and vector enables
  ioShim i_ioShim (
    .HCLK       (HCLK),
    .arstN      (arstN),
    .sicSources (sicSources),
    .bus        (ioBus.slave),
    .irq        (irq),
    .fiq        (fiq)
  );

endmodule : ahbLite

`default_nettype wire

//--- hdl/ahbLitePkg.sv
`default_nettype none

// shared types for the bus fabric, the slaves and the testbench model
package ahbLitePkg;

  // transfer size as driven on HSIZE
  // encodings follow the usual ahb values
  typedef enum logic [2:0] {
    sizeByte = 3'b000,
    sizeHalf = 3'b001,
    sizeWord = 3'b010
  } hSizeT;

  // which slave owns the current address
  // noneSel means the fabric answers by itself
  typedef enum logic [1:0] {
    memSel  = 2'd0,
    ioSel   = 2'd1,
    noneSel = 2'd2
  } slaveSelT;

endpackage : ahbLitePkg

`default_nettype wire

//--- hdl/ahbLite_defines.svh
`ifndef AHBLITE_DEFINES_SVH
`define AHBLITE_DEFINES_SVH

// memory depth in 32-bit words
`define MEM_WORDS 256

// region codes, compared against HADDR[31:28]
`define REGION_MEM 4'h0
`define REGION_IO  4'h4

// io register word offsets, taken from HADDR[4:2]
`define IO_SIC_STATUS 3'd0
`define IO_SIC_ENABLE 3'd1
`define IO_SIC_CLEAR  3'd2
`define IO_IRQ_ENABLE 3'd3
`define IO_FIQ_ENABLE 3'd4
`define IO_SCRATCH    3'd5

// secondary interrupt controller
`define SIC_WIDTH 8
// where the sic line sits in the raw irq/fiq vectors
`define SIC_IRQ_BIT 26

`endif

//--- hdl/ahbSlaveIf.sv
`timescale 1ns/1ps
`default_nettype none

// one slave port of the fabric
// request side flows fabric to slave, response side the other way
interface ahbSlaveIf
  import ahbLitePkg::*;
();

  // address decode hit for this slave
  logic        sel;
  // HREQUEST, gated by sel
  logic        req;
  logic        write;
  hSizeT       size;
  logic [31:0] addr;
  logic [31:0] wdata;

  // response
  logic [31:0] rdata;
  // one cycle per transfer
  logic        ready;

  modport fabric (
    output sel, req, write, size, addr, wdata,
    input  rdata, ready
  );

  modport slave (
    input  sel, req, write, size, addr, wdata,
    output rdata, ready
  );

endinterface : ahbSlaveIf

`default_nettype wire

//--- hdl/busFabric.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahbLite_defines.svh"

// address decoder plus response mux between the master and the two slaves
// unmapped accesses are answered here with zero data
module busFabric
  import ahbLitePkg::*;
(
  input  logic        HCLK,
  input  logic        arstN,
  input  logic        HREQUEST,
  input  hSizeT       HSIZE,
  input  logic [31:0] HADDR,
  input  logic        HWRITE,
  input  logic [31:0] HWDATA,
  output logic [31:0] HRDATA,
  output logic        HREADY,
  ahbSlaveIf.fabric   memBus,
  ahbSlaveIf.fabric   ioBus
);

  slaveSelT decSel;
  // ready for unmapped transfers
  logic     noneReady;

  // region from the top nibble only
  // everything else in the map aliases
  always_comb begin
    case (HADDR[31:28])
      `REGION_MEM: decSel = memSel;
      `REGION_IO:  decSel = ioSel;
      default:     decSel = noneSel;
    endcase
  end

  // select lines, at most one high
  assign memBus.sel = (decSel == memSel);
  assign ioBus.sel  = (decSel == ioSel);

  // request only reaches the selected slave
  assign memBus.req = HREQUEST && memBus.sel;
  assign ioBus.req  = HREQUEST && ioBus.sel;

  // address, control and write data are broadcast
  assign memBus.write = HWRITE;
  assign memBus.size  = HSIZE;
  assign memBus.addr  = HADDR;
  assign memBus.wdata = HWDATA;
  assign ioBus.write  = HWRITE;
  assign ioBus.size   = HSIZE;
  assign ioBus.addr   = HADDR;
  assign ioBus.wdata  = HWDATA;

  // unmapped: one cycle, then one idle cycle if the request is held
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      noneReady <= 1'b0;
    end else begin
      noneReady <= HREQUEST && (decSel == noneSel) && !noneReady;
    end
  end

  // response mux, address is held so decSel is still valid here
  always_comb begin
    case (decSel)
      memSel: begin
        HRDATA = memBus.rdata;
        HREADY = memBus.ready;
      end
      ioSel: begin
        HRDATA = ioBus.rdata;
        HREADY = ioBus.ready;
      end
      default: begin
        // unmapped reads give zero
        HRDATA = 32'h0;
        HREADY = noneReady;
      end
    endcase
  end

  // never two slaves selected at once
  assert property (@(posedge HCLK) disable iff (!arstN)
    !(memBus.sel && ioBus.sel));

  // ready only comes back to a master that is still requesting
  assert property (@(posedge HCLK) disable iff (!arstN)
    HREADY |-> HREQUEST);

endmodule : busFabric

`default_nettype wire

//--- hdl/dataMemAhb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahbLite_defines.svh"

// byte addressable word memory behind the fabric
// one wait state, ready in the second cycle after the request edge
module dataMemAhb
  import ahbLitePkg::*;
(
  input logic       HCLK,
  input logic       arstN,
  ahbSlaveIf.slave  bus
);

  localparam int AW = $clog2(`MEM_WORDS);

  logic [31:0]   mem [`MEM_WORDS];
  logic [AW-1:0] wordIdx;
  logic [3:0]    byteEn;
  // wait state in progress, also the busy flag
  logic          waitCnt;
  logic          start;

  // word address, low two bits pick the lanes
  assign wordIdx = bus.addr[AW+1:2];

  // new transfer only once the previous one has fully retired
  assign start = bus.sel && bus.req && !waitCnt && !bus.ready;

  // lane mask from size and the low address bits
  always_comb begin
    byteEn = 4'b0000;
    case (bus.size)
      sizeByte: begin
        byteEn[bus.addr[1:0]] = 1'b1;
      end
      sizeHalf: begin
        // upper or lower half
        byteEn = bus.addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        byteEn = 4'b1111;
      end
    endcase
  end

  // control: idle -> wait -> ready -> idle
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      waitCnt   <= 1'b0;
      bus.ready <= 1'b0;
    end else begin
      waitCnt   <= start;
      bus.ready <= waitCnt;
    end
  end

  // storage and read data
  always_ff @(posedge HCLK) begin
    // write lands at the edge that closes the ready cycle
    if (bus.ready && bus.write) begin
      for (int i = 0; i < 4; i++) begin
        if (byteEn[i]) begin
          mem[wordIdx][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
    // full word captured as ready rises
    if (waitCnt) begin
      bus.rdata <= mem[wordIdx];
    end
  end

  // ready is a single pulse
  assert property (@(posedge HCLK) disable iff (!arstN)
    bus.ready |=> !bus.ready);

  // master and fabric still hold the request while we answer
  assert property (@(posedge HCLK) disable iff (!arstN)
    bus.ready |-> (bus.sel && bus.req));

endmodule : dataMemAhb

`default_nettype wire

//--- hdl/ioShim.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahbLite_defines.svh"

// io register block: secondary interrupt controller, vector enables, scratch
// single cycle access, full word writes regardless of size
module ioShim
  import ahbLitePkg::*;
(
  input  logic                  HCLK,
  input  logic                  arstN,
  input  logic [`SIC_WIDTH-1:0] sicSources,
  ahbSlaveIf.slave              bus,
  output logic                  irq,
  output logic                  fiq
);

  logic [2:0]            offset;
  logic                  ioWrite;
  logic [`SIC_WIDTH-1:0] sicPending;
  logic [`SIC_WIDTH-1:0] sicEnable;
  logic [`SIC_WIDTH-1:0] clrMask;
  logic [31:0]           irqEnable;
  logic [31:0]           fiqEnable;
  logic [31:0]           scratch;
  // any pending source that is enabled
  logic                  sicInterrupt;
  logic [31:0]           rawIrqVec;
  logic [31:0]           rawFiqVec;

  assign offset = bus.addr[4:2];

  // register update at the edge that ends the ready cycle
  assign ioWrite = bus.ready && bus.write;

  // ready pulse, low cycle in between doubles as busy
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.sel && bus.req && !bus.ready;
    end
  end

  // write one to clear
  assign clrMask = (ioWrite && (offset == `IO_SIC_CLEAR)) ?
                   bus.wdata[`SIC_WIDTH-1:0] : '0;

  // sticky pending, a set in the same cycle beats the clear
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      sicPending <= '0;
    end else begin
      sicPending <= (sicPending & ~clrMask) | sicSources;
    end
  end

  // enables and scratch
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      sicEnable <= '0;
      irqEnable <= 32'h0;
      fiqEnable <= 32'h0;
      scratch   <= 32'h0;
    end else if (ioWrite) begin
      case (offset)
        `IO_SIC_ENABLE: sicEnable <= bus.wdata[`SIC_WIDTH-1:0];
        `IO_IRQ_ENABLE: irqEnable <= bus.wdata;
        `IO_FIQ_ENABLE: fiqEnable <= bus.wdata;
        `IO_SCRATCH:    scratch   <= bus.wdata;
        // status is read only, clear handled above
        default: ;
      endcase
    end
  end

  // read mux straight from the registers
  always_comb begin
    case (offset)
      `IO_SIC_STATUS: bus.rdata = 32'(sicPending);
      `IO_SIC_ENABLE: bus.rdata = 32'(sicEnable);
      `IO_IRQ_ENABLE: bus.rdata = irqEnable;
      `IO_FIQ_ENABLE: bus.rdata = fiqEnable;
      `IO_SCRATCH:    bus.rdata = scratch;
      // clear reads as zero, as do the holes
      default:        bus.rdata = 32'h0;
    endcase
  end

  assign sicInterrupt = |(sicPending & sicEnable);

  // raw vectors, only the sic line is live
  always_comb begin
    rawIrqVec = 32'h0;
    rawFiqVec = 32'h0;
    rawIrqVec[`SIC_IRQ_BIT] = sicInterrupt;
    rawFiqVec[`SIC_IRQ_BIT] = sicInterrupt;
  end

  // enable gating and reduction
  assign irq = |(rawIrqVec & irqEnable);
  assign fiq = |(rawFiqVec & fiqEnable);

  // one ready per request
  assert property (@(posedge HCLK) disable iff (!arstN)
    bus.ready |=> !bus.ready);

endmodule : ioShim

`default_nettype wire

//--- tests/ahbLiteChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahbLite_defines.svh"

// watches the dut ports and compares them against a reference model
// all sampling on the falling edge, where the ports have settled
module ahbLiteChecker
  import ahbLitePkg::*;
(
  input  logic                  HCLK,
  input  logic                  arstN,
  input  logic                  HREQUEST,
  input  hSizeT                 HSIZE,
  input  logic [31:0]           HADDR,
  input  logic                  HWRITE,
  input  logic [31:0]           HWDATA,
  input  logic [`SIC_WIDTH-1:0] sicSources,
  input  logic [31:0]           HRDATA,
  input  logic                  HREADY,
  input  logic                  irq,
  input  logic                  fiq,
  output int                    checkCount,
  output int                    errorCount
);

  // memory model, with a mask of the bytes written so far
  logic [31:0]           memModel [`MEM_WORDS];
  logic [3:0]            memKnown [`MEM_WORDS];
  // io register model
  logic [`SIC_WIDTH-1:0] pendModel;
  logic [`SIC_WIDTH-1:0] sicEnModel;
  logic [31:0]           irqEnModel;
  logic [31:0]           fiqEnModel;
  logic [31:0]           scratchModel;
  logic                  sicModel;
  // falling edges seen with the request high
  int                    reqCycles;

  initial begin
    checkCount = 0;
    errorCount = 0;
    reqCycles  = 0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      memKnown[i] = 4'b0000;
    end
  end

  // top nibble picks the slave
  function automatic slaveSelT regionOf(input logic [31:0] addr);
    if (addr[31:28] == `REGION_MEM) begin
      return memSel;
    end
    if (addr[31:28] == `REGION_IO) begin
      return ioSel;
    end
    return noneSel;
  endfunction

  // lanes written for a size and the two low address bits
  function automatic logic [3:0] lanesOf(input hSizeT size, input logic [1:0] low);
    case (size)
      sizeByte: return 4'b0001 << low;
      sizeHalf: return low[1] ? 4'b1100 : 4'b0011;
      default:  return 4'b1111;
    endcase
  endfunction

  // read value of an io word offset
  function automatic logic [31:0] ioReadValue(input logic [2:0] offset);
    case (offset)
      `IO_SIC_STATUS: return 32'(pendModel);
      `IO_SIC_ENABLE: return 32'(sicEnModel);
      `IO_IRQ_ENABLE: return irqEnModel;
      `IO_FIQ_ENABLE: return fiqEnModel;
      `IO_SCRATCH:    return scratchModel;
      default:        return 32'h0;
    endcase
  endfunction

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  always @(negedge HCLK) begin : watch
    slaveSelT              sel;
    logic [7:0]            idx;
    logic [3:0]            lanes;
    logic [31:0]           bitMask;
    logic [`SIC_WIDTH-1:0] clrMask;
    sel     = regionOf(HADDR);
    idx     = HADDR[9:2];
    lanes   = lanesOf(HSIZE, HADDR[1:0]);
    clrMask = '0;
    if (!arstN) begin
      // everything quiet while in reset
      compare(32'(HREADY), 32'h0, "HREADY in reset");
      compare(32'(irq), 32'h0, "irq in reset");
      compare(32'(fiq), 32'h0, "fiq in reset");
      pendModel    = '0;
      sicEnModel   = '0;
      irqEnModel   = 32'h0;
      fiqEnModel   = 32'h0;
      scratchModel = 32'h0;
      reqCycles    = 0;
    end else begin
      // interrupt outputs from the state before the coming edge
      sicModel = |(pendModel & sicEnModel);
      compare(32'(irq), 32'(sicModel & irqEnModel[`SIC_IRQ_BIT]), "irq");
      compare(32'(fiq), 32'(sicModel & fiqEnModel[`SIC_IRQ_BIT]), "fiq");
      if (HREQUEST) begin
        reqCycles++;
        if (HREADY) begin
          // memory has one wait state, the rest answer at once
          compare(32'(reqCycles), (sel == memSel) ? 32'd3 : 32'd2, "HREADY latency");
          reqCycles = 0;
          if (!HWRITE) begin
            if (sel == memSel) begin
              // only bytes that were written are known
              for (int i = 0; i < 4; i++) begin
                bitMask[8*i +: 8] = {8{memKnown[idx][i]}};
              end
              compare(HRDATA & bitMask, memModel[idx] & bitMask, "memory read");
            end else if (sel == ioSel) begin
              compare(HRDATA, ioReadValue(HADDR[4:2]), "io read");
            end else begin
              compare(HRDATA, 32'h0, "unmapped read");
            end
          end else if (sel == memSel) begin
            for (int i = 0; i < 4; i++) begin
              if (lanes[i]) begin
                memModel[idx][8*i +: 8] = HWDATA[8*i +: 8];
                memKnown[idx][i] = 1'b1;
              end
            end
          end else if (sel == ioSel) begin
            // full word, size ignored
            case (HADDR[4:2])
              `IO_SIC_ENABLE: sicEnModel = HWDATA[`SIC_WIDTH-1:0];
              `IO_SIC_CLEAR:  clrMask = HWDATA[`SIC_WIDTH-1:0];
              `IO_IRQ_ENABLE: irqEnModel = HWDATA;
              `IO_FIQ_ENABLE: fiqEnModel = HWDATA;
              `IO_SCRATCH:    scratchModel = HWDATA;
              default: ;
            endcase
          end
        end
      end else begin
        reqCycles = 0;
        compare(32'(HREADY), 32'h0, "HREADY without request");
      end
      // sticky set beats the clear
      pendModel = (pendModel & ~clrMask) | sicSources;
    end
  end

endmodule : ahbLiteChecker

`default_nettype wire

//--- tests/ahbLiteTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahbLite_defines.svh"

// random transfers over memory, io and unmapped space, random sic pulses
module ahbLiteTb
  import ahbLitePkg::*;
();

  localparam int NUM_TRANSFERS = 800;
  // cycles to wait for HREADY before giving up
  localparam int READY_TIMEOUT = 20;

  logic                  HCLK = 1'b0;
  logic                  arstN;
  logic                  HREQUEST;
  hSizeT                 HSIZE;
  logic [31:0]           HADDR;
  logic                  HWRITE;
  logic [31:0]           HWDATA;
  logic [`SIC_WIDTH-1:0] sicSources;
  logic [31:0]           HRDATA;
  logic                  HREADY;
  logic                  irq;
  logic                  fiq;
  int                    checkCount;
  int                    errorCount;
  bit                    hung;

  always #5 HCLK = ~HCLK;

  ahbLite i_ahbLite (
    .HCLK       (HCLK),
    .arstN      (arstN),
    .HREQUEST   (HREQUEST),
    .HSIZE      (HSIZE),
    .HADDR      (HADDR),
    .HWRITE     (HWRITE),
    .HWDATA     (HWDATA),
    .sicSources (sicSources),
    .HRDATA     (HRDATA),
    .HREADY     (HREADY),
    .irq        (irq),
    .fiq        (fiq)
  );

  ahbLiteChecker i_ahbLiteChecker (
    .HCLK       (HCLK),
    .arstN      (arstN),
    .HREQUEST   (HREQUEST),
    .HSIZE      (HSIZE),
    .HADDR      (HADDR),
    .HWRITE     (HWRITE),
    .HWDATA     (HWDATA),
    .sicSources (sicSources),
    .HRDATA     (HRDATA),
    .HREADY     (HREADY),
    .irq        (irq),
    .fiq        (fiq),
    .checkCount (checkCount),
    .errorCount (errorCount)
  );

  // one rising edge, with an occasional burst on the sic sources
  task automatic nextCycle();
    @(posedge HCLK);
    if (arstN && ($urandom_range(7) == 0)) begin
      sicSources <= `SIC_WIDTH'($urandom);
    end else begin
      sicSources <= '0;
    end
  endtask

  // poll HREADY on falling edges
  task automatic waitReady(output bit ok);
    int cycles;
    ok = 1'b0;
    for (cycles = 0; cycles < READY_TIMEOUT; cycles++) begin
      @(negedge HCLK);
      if (HREADY) begin
        ok = 1'b1;
        break;
      end
      nextCycle();
    end
    if (!ok) begin
      $display("timeout at %0t ns: HREADY stayed low for %0d cycles of a request at 0x%08h",
               $time, READY_TIMEOUT, HADDR);
    end
  endtask

  task automatic runTransfer(output bit ok);
    int          roll;
    logic [3:0]  region;
    hSizeT       size;
    logic [31:0] addr;
    // mostly memory, some io, a few unmapped
    roll = $urandom_range(9);
    if (roll < 6) begin
      region = `REGION_MEM;
    end else if (roll < 9) begin
      region = `REGION_IO;
    end else begin
      // 1..3 and 5..15
      region = 4'($urandom_range(14, 1));
      if (region >= 4) begin
        region = region + 4'd1;
      end
    end
    case ($urandom_range(2))
      0:       size = sizeByte;
      1:       size = sizeHalf;
      default: size = sizeWord;
    endcase
    // small word window so reads hit earlier writes, upper bits alias
    addr        = $urandom;
    addr[31:28] = region;
    addr[9:2]   = 8'($urandom_range(31));
    if (size == sizeHalf) begin
      addr[0] = 1'b0;
    end else if (size == sizeWord) begin
      addr[1:0] = 2'b00;
    end
    nextCycle();
    HREQUEST <= 1'b1;
    HWRITE   <= 1'($urandom);
    HSIZE    <= size;
    HADDR    <= addr;
    HWDATA   <= $urandom;
    waitReady(ok);
    // release after the ready cycle
    nextCycle();
    HREQUEST <= 1'b0;
  endtask

  initial begin
    bit ok;
    void'($urandom(32'hfd1a_8dd0));
    hung       = 1'b0;
    arstN      = 1'b0;
    HREQUEST   = 1'b0;
    HSIZE      = sizeWord;
    HADDR      = 32'h0;
    HWRITE     = 1'b0;
    HWDATA     = 32'h0;
    sicSources = '0;
    repeat (10) nextCycle();
    arstN <= 1'b1;
    // quiet bus for a while, sources alone must not raise anything
    repeat (5) nextCycle();
    for (int n = 0; (n < NUM_TRANSFERS) && !hung; n++) begin
      runTransfer(ok);
      if (!ok) begin
        hung = 1'b1;
      end
      repeat ($urandom_range(2)) nextCycle();
    end
    repeat (4) nextCycle();
    $display("checks: %0d, errors: %0d, hung: %0d", checkCount, errorCount, hung);
    if (hung || (errorCount != 0)) begin
      $display("Finished with errors");
    end else begin
      $display("Finished with no errors");
    end
    $finish;
  end

endmodule : ahbLiteTb

`default_nettype wire
